/* all.f */
source/soc_periph_pkg.sv
source/apb_periph_decode.sv
source/gpio_regs.sv
source/event_fifo.sv
source/soc_event_gen.sv
source/soc_peripherals.sv
sim/tb_soc_peripherals.sv

/* Bender.yml */
package:
  name: soc_peripherals

sources:
  - source/soc_periph_pkg.sv
  - source/apb_periph_decode.sv
  - source/gpio_regs.sv
  - source/event_fifo.sv
  - source/soc_event_gen.sv
  - source/soc_peripherals.sv
  - target: test
    files:
      - sim/tb_soc_peripherals.sv

/* sim/tb_soc_peripherals.sv */
// testbench for the soc peripheral subsystem with apb stimulus, an event model and checks
`timescale 1ns/10ps

module tb_soc_peripherals;

    localparam int          FIFO_DEPTH  = 4;
    localparam int          SYNC_STAGES = 2;
    localparam logic [31:0] SEED        = 32'hefd4_b45c;
    localparam int          PER_IDX [5] = '{
        soc_periph_pkg::PER_DMA_EVT, soc_periph_pkg::PER_DMA_IRQ, soc_periph_pkg::PER_PF_EVT,
        soc_periph_pkg::PER_HWPE0, soc_periph_pkg::PER_HWPE1
    };

    logic                      clk_i;
    logic                      reset_i;
    soc_periph_pkg::apb_addr_t paddr_i;
    logic                      psel_i;
    logic                      penable_i;
    logic                      pwrite_i;
    soc_periph_pkg::apb_data_t pwdata_i;
    soc_periph_pkg::apb_data_t prdata_o;
    logic                      pready_o;
    logic                      pslverr_o;
    soc_periph_pkg::gpio_t     gpio_i;
    soc_periph_pkg::gpio_t     gpio_out_o;
    soc_periph_pkg::gpio_t     gpio_dir_o;
    logic                      slow_clk_i;
    logic                      dma_pe_evt_i;
    logic                      dma_pe_irq_i;
    logic                      pf_evt_i;
    logic [1:0]                fc_hwpe_events_i;
    soc_periph_pkg::fc_evt_t   fc_events_o;
    logic                      fc_event_valid_o;
    soc_periph_pkg::event_id_t fc_event_data_o;
    logic                      fc_event_ready_i;

    logic [31:0] rng;
    logic [31:0] rdy_rng;       // separate stream for the ready driver
    logic        hold_ready;
    logic        hold_pending;
    logic [7:0]  held_id;
    logic        err_seen;
    logic        edge_seen;
    logic        gpio_seen;
    int          exp_cnt [16];  // model of queued ids
    int          outstanding;

    soc_peripherals #(
        .FIFO_DEPTH  ( FIFO_DEPTH  ),
        .SYNC_STAGES ( SYNC_STAGES )
    ) u_soc_peripherals (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_run();
        end
    endtask

    task automatic report_problem(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk_i);             // setup phase
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);             // sample mid access cycle
        rdata = prdata_o;
        err   = pslverr_o;
        check_value("pready_o", pready_o, 1'b1);
        @(posedge clk_i);             // write lands here
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check_value("pslverr_o", err, 1'b0);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata);
        logic err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_value("pslverr_o", err, 1'b0);
    endtask

    task automatic add_expected(input int id);
        exp_cnt[id]++;
        outstanding++;
    endtask

    task automatic drain_events();
        for (int i = 0; i < 400 && outstanding > 0; i++) begin
            @(negedge clk_i);
        end
        if (outstanding != 0) begin
            report_problem("timeout while waiting for queued events to drain");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // fabric controller side, random ready and output monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk_i) begin
        rdy_rng = xorshift32(rdy_rng);
        fc_event_ready_i <= hold_ready ? 1'b0 : rdy_rng[7];
    end

    always @(negedge clk_i) begin
        int id;
        if (!reset_i) begin
            if (hold_pending) begin     // held last cycle, must not move
                check_value("fc_event_valid_o", fc_event_valid_o, 1'b1);
                check_value("fc_event_data_o", fc_event_data_o, held_id);
            end
            hold_pending = fc_event_valid_o && !fc_event_ready_i;
            held_id      = fc_event_data_o;
            if (fc_event_valid_o && fc_event_ready_i) begin
                id = fc_event_data_o;
                if (id >= 16 || exp_cnt[id] == 0) begin
                    report_problem($sformatf("event id %0d came out but was not pending", id));
                end
                exp_cnt[id]--;
                outstanding--;
            end
            if (fc_events_o[soc_periph_pkg::FC_ERR])      err_seen = 1'b1;
            if (fc_events_o[soc_periph_pkg::FC_REF_EDGE]) edge_seen = 1'b1;
            if (fc_events_o[soc_periph_pkg::FC_GPIO])     gpio_seen = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] d;
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] m;
        logic [31:0] a;
        logic [31:0] exp_fast;
        logic        err;
        int          n;
        reset_i = 1'b1;
        paddr_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        pwdata_i = '0;
        gpio_i = '0;
        slow_clk_i = 1'b0;
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i = 1'b0;
        fc_hwpe_events_i = '0;
        fc_event_ready_i = 1'b0;
        rng = SEED;
        rdy_rng = ~SEED;
        hold_ready = 1'b1;
        hold_pending = 1'b0;
        held_id = '0;
        err_seen = 1'b0;
        edge_seen = 1'b0;
        gpio_seen = 1'b0;
        outstanding = 0;
        foreach (exp_cnt[i]) exp_cnt[i] = 0;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_value("gpio_out_o", gpio_out_o, '0);
        check_value("gpio_dir_o", gpio_dir_o, '0);
        check_value("fc_event_valid_o", fc_event_valid_o, 1'b0);
        check_value("fc_events_o", fc_events_o, '0);
        check_value("prdata_o", prdata_o, '0);
        check_value("pslverr_o", pslverr_o, 1'b0);

        // gpio registers and input path
        for (int k = 0; k < 6; k++) begin
            d = rand32();
            apb_write(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_DIR, d);
            apb_read(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_DIR, r);
            check_value("GPIO_DIR", r, d);
            check_value("gpio_dir_o", gpio_dir_o, d);
            d = rand32();
            apb_write(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_OUT, d);
            apb_read(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_OUT, r);
            check_value("GPIO_OUT", r, d);
            check_value("gpio_out_o", gpio_out_o, d);
            d = rand32();
            apb_write(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTEN, d);
            apb_read(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTEN, r);
            check_value("GPIO_INTEN", r, d);
            d = rand32();
            @(posedge clk_i);
            gpio_i <= d;
            repeat (5) @(posedge clk_i);
            apb_read(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_IN, r);
            check_value("GPIO_IN", r, d);
        end

        // gpio interrupts, pins start low so only new rising edges count
        for (int k = 0; k < 8; k++) begin
            @(posedge clk_i);
            gpio_i <= '0;
            repeat (5) @(posedge clk_i);
            apb_write(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTSTAT, '1);
            m = rand32();
            apb_write(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTEN, m);
            d = rand32();
            gpio_seen = 1'b0;
            @(posedge clk_i);
            gpio_i <= d;
            repeat (5) @(posedge clk_i);
            check_value("fc_events_o[15]", gpio_seen, |(d & m));
            apb_read(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTSTAT, r);
            check_value("GPIO_INTSTAT", r, d & m);
            apb_write(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTSTAT, d & m);
            apb_read(soc_periph_pkg::GPIO_BASE + soc_periph_pkg::GPIO_INTSTAT, r);
            check_value("GPIO_INTSTAT", r, '0);
        end

        // software events with random back-pressure
        hold_ready = 1'b0;
        for (int k = 0; k < 12; k++) begin
            v = rand32() & 32'hff;
            for (int i = 0; i < soc_periph_pkg::SW_EVT_NUM; i++) begin
                if (v[i]) add_expected(i);
            end
            apb_write(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_SW, v);
            drain_events();
        end
        apb_read(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_SW, r);
        check_value("EVT_SW", r, '0);
        apb_read(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_ERR, r);
        check_value("EVT_ERR", r, '0);

        // peripheral events through the mask, plus the fast vector
        m = rand32() & 32'hff;
        apb_write(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_MASK, m);
        apb_read(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_MASK, r);
        check_value("EVT_MASK", r, m);
        for (int k = 0; k < 8; k++) begin
            v = rand32();
            for (int i = 0; i < 5; i++) begin
                if (v[i] && m[PER_IDX[i]]) add_expected(soc_periph_pkg::SW_EVT_NUM + PER_IDX[i]);
            end
            exp_fast = '0;
            exp_fast[soc_periph_pkg::FC_DMA_EVT] = v[0];
            exp_fast[soc_periph_pkg::FC_DMA_IRQ] = v[1];
            exp_fast[soc_periph_pkg::FC_PF_EVT]  = v[2];
            @(posedge clk_i);
            dma_pe_evt_i     <= v[0];
            dma_pe_irq_i     <= v[1];
            pf_evt_i         <= v[2];
            fc_hwpe_events_i <= v[4:3];
            @(negedge clk_i);
            check_value("fc_events_o", fc_events_o, exp_fast);
            @(posedge clk_i);
            dma_pe_evt_i     <= 1'b0;
            dma_pe_irq_i     <= 1'b0;
            pf_evt_i         <= 1'b0;
            fc_hwpe_events_i <= '0;
            drain_events();
        end

        // reference clock rise then fall
        for (int k = 0; k < 2; k++) begin
            n = (k == 0) ? soc_periph_pkg::PER_REF_RISE : soc_periph_pkg::PER_REF_FALL;
            if (m[n]) add_expected(soc_periph_pkg::SW_EVT_NUM + n);
            edge_seen = 1'b0;
            @(posedge clk_i);
            slow_clk_i <= (k == 0);
            for (int i = 0; i < 20 && !edge_seen; i++) @(negedge clk_i);
            if (!edge_seen) report_problem("timeout waiting for the reference edge fast event");
            drain_events();
        end

        // overflow, one more write than fifo plus pending can hold
        hold_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        n = rand32() % soc_periph_pkg::SW_EVT_NUM;
        err_seen = 1'b0;
        for (int k = 0; k < FIFO_DEPTH + 1; k++) add_expected(n);
        for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
            if (k == FIFO_DEPTH + 1) check_value("fc_events_o[29] before overflow", err_seen, 1'b0);
            apb_write(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_SW, 32'h1 << n);
        end
        for (int i = 0; i < 10 && !err_seen; i++) @(negedge clk_i);
        if (!err_seen) report_problem("timeout waiting for the overflow fast event");
        apb_read(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_ERR, r);
        check_value("EVT_ERR", r, 32'h1 << n);
        apb_write(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_ERR, 32'h1 << n);
        apb_read(soc_periph_pkg::EVT_BASE + soc_periph_pkg::EVT_ERR, r);
        check_value("EVT_ERR", r, '0);
        hold_ready = 1'b0;
        drain_events();

        // unmapped regions answer with an error and zero data
        for (int k = 0; k < 4; k++) begin
            a = rand32();
            while ((a & ~soc_periph_pkg::REGION_MASK) == soc_periph_pkg::GPIO_BASE ||
                   (a & ~soc_periph_pkg::REGION_MASK) == soc_periph_pkg::EVT_BASE) begin
                a = rand32();
            end
            apb_access(1'b0, a, '0, r, err);
            check_value("prdata_o", r, '0);
            check_value("pslverr_o", err, 1'b1);
            apb_access(1'b1, a, rand32(), r, err);
            check_value("pslverr_o", err, 1'b1);
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* source/soc_peripherals.sv */
// soc peripheral subsystem top with apb decode, gpio, event generator and fast events
`timescale 1ns/10ps

module soc_peripherals #(
    parameter int FIFO_DEPTH  = 4,
    parameter int SYNC_STAGES = 2
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  soc_periph_pkg::gpio_t     gpio_i,
    output soc_periph_pkg::gpio_t     gpio_out_o,
    output soc_periph_pkg::gpio_t     gpio_dir_o,
    input  logic                      slow_clk_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      dma_pe_irq_i,
    input  logic                      pf_evt_i,
    input  logic [1:0]                fc_hwpe_events_i,
    output soc_periph_pkg::fc_evt_t   fc_events_o,
    output logic                      fc_event_valid_o,
    output soc_periph_pkg::event_id_t fc_event_data_o,
    input  logic                      fc_event_ready_i
);

    logic                      gpio_psel;
    logic                      evt_psel;
    soc_periph_pkg::apb_addr_t offset;
    soc_periph_pkg::apb_data_t gpio_prdata;
    soc_periph_pkg::apb_data_t evt_prdata;
    soc_periph_pkg::per_evt_t  per_events;
    logic                      gpio_event;
    logic                      ref_rise;
    logic                      ref_fall;
    logic                      err_event;

    ////////////////////////////////////////////////////////////
    // event routing
    ////////////////////////////////////////////////////////////
    always_comb begin
        per_events = '0;
        per_events[soc_periph_pkg::PER_GPIO]     = gpio_event;
        per_events[soc_periph_pkg::PER_REF_RISE] = ref_rise;   // looped back from the generator
        per_events[soc_periph_pkg::PER_REF_FALL] = ref_fall;
        per_events[soc_periph_pkg::PER_DMA_EVT]  = dma_pe_evt_i;
        per_events[soc_periph_pkg::PER_DMA_IRQ]  = dma_pe_irq_i;
        per_events[soc_periph_pkg::PER_PF_EVT]   = pf_evt_i;
        per_events[soc_periph_pkg::PER_HWPE0]    = fc_hwpe_events_i[0];
        per_events[soc_periph_pkg::PER_HWPE1]    = fc_hwpe_events_i[1];
    end

    // fast events, bits of removed sources stay low
    always_comb begin
        fc_events_o = '0;
        fc_events_o[soc_periph_pkg::FC_DMA_EVT]  = dma_pe_evt_i;
        fc_events_o[soc_periph_pkg::FC_DMA_IRQ]  = dma_pe_irq_i;
        fc_events_o[soc_periph_pkg::FC_PF_EVT]   = pf_evt_i;
        fc_events_o[soc_periph_pkg::FC_REF_EDGE] = ref_rise | ref_fall;
        fc_events_o[soc_periph_pkg::FC_GPIO]     = gpio_event;
        fc_events_o[soc_periph_pkg::FC_ERR]      = err_event;
    end

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////
    apb_periph_decode u_apb_periph_decode (
        .paddr_i       ( paddr_i     ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .gpio_prdata_i ( gpio_prdata ),
        .evt_prdata_i  ( evt_prdata  ),
        .gpio_psel_o   ( gpio_psel   ),
        .evt_psel_o    ( evt_psel    ),
        .offset_o      ( offset      ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    gpio_regs #(
        .SYNC_STAGES ( SYNC_STAGES )
    ) u_gpio_regs (
        .clk_i        ( clk_i       ),
        .reset_i      ( reset_i     ),
        .psel_i       ( gpio_psel   ),
        .penable_i    ( penable_i   ),
        .pwrite_i     ( pwrite_i    ),
        .offset_i     ( offset      ),
        .pwdata_i     ( pwdata_i    ),
        .prdata_o     ( gpio_prdata ),
        .gpio_i       ( gpio_i      ),
        .gpio_out_o   ( gpio_out_o  ),
        .gpio_dir_o   ( gpio_dir_o  ),
        .gpio_event_o ( gpio_event  )
    );

    soc_event_gen #(
        .FIFO_DEPTH  ( FIFO_DEPTH  ),
        .SYNC_STAGES ( SYNC_STAGES )
    ) u_soc_event_gen (
        .clk_i            ( clk_i            ),
        .reset_i          ( reset_i          ),
        .psel_i           ( evt_psel         ),
        .penable_i        ( penable_i        ),
        .pwrite_i         ( pwrite_i         ),
        .offset_i         ( offset           ),
        .pwdata_i         ( pwdata_i         ),
        .prdata_o         ( evt_prdata       ),
        .slow_clk_i       ( slow_clk_i       ),
        .ref_rise_o       ( ref_rise         ),
        .ref_fall_o       ( ref_fall         ),
        .per_events_i     ( per_events       ),
        .err_event_o      ( err_event        ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .fc_event_ready_i ( fc_event_ready_i )
    );

endmodule

/* source/soc_event_gen.sv */
// soc event generator, pends software and peripheral events and queues them by priority
`timescale 1ns/10ps

module soc_event_gen #(
    parameter int FIFO_DEPTH  = 4,
    parameter int SYNC_STAGES = 2
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t offset_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    input  logic                      slow_clk_i,
    output logic                      ref_rise_o,
    output logic                      ref_fall_o,
    input  soc_periph_pkg::per_evt_t  per_events_i,
    output logic                      err_event_o,
    output logic                      fc_event_valid_o,
    output soc_periph_pkg::event_id_t fc_event_data_o,
    input  logic                      fc_event_ready_i
);

    localparam int SW_NUM  = soc_periph_pkg::SW_EVT_NUM;
    localparam int EVT_NUM = soc_periph_pkg::SW_EVT_NUM + soc_periph_pkg::PER_EVT_NUM;

    logic [SYNC_STAGES-1:0]    slow_sync_q;
    logic                      slow_prev_q;
    logic                      ref_rise_q;
    logic                      ref_fall_q;
    soc_periph_pkg::per_evt_t  mask_q;
    logic [EVT_NUM-1:0]        pending_q;
    logic [EVT_NUM-1:0]        err_q;
    logic [EVT_NUM-1:0]        evt_in;
    logic [EVT_NUM-1:0]        grant;
    logic [EVT_NUM-1:0]        clr;
    logic [EVT_NUM-1:0]        lost;
    logic [EVT_NUM-1:0]        err_clr;
    logic [SW_NUM-1:0]         sw_set;
    logic                      err_event_q;
    logic                      wr_en;
    logic                      push;
    logic                      fifo_full;
    soc_periph_pkg::event_id_t win_id;

    ////////////////////////////////////////////////////////////
    // slow clock edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slow_sync_q <= '0;
            slow_prev_q <= 1'b0;
            ref_rise_q  <= 1'b0;
            ref_fall_q  <= 1'b0;
        end else begin
            slow_sync_q <= {slow_sync_q[SYNC_STAGES-2:0], slow_clk_i};
            slow_prev_q <= slow_sync_q[SYNC_STAGES-1];
            ref_rise_q  <= slow_sync_q[SYNC_STAGES-1] & ~slow_prev_q;
            ref_fall_q  <= ~slow_sync_q[SYNC_STAGES-1] & slow_prev_q;
        end
    end

    assign ref_rise_o = ref_rise_q;
    assign ref_fall_o = ref_fall_q;

    ////////////////////////////////////////////////////////////
    // pending vector and arbiter
    ////////////////////////////////////////////////////////////
    assign wr_en   = psel_i & penable_i & pwrite_i;
    assign sw_set  = (wr_en && offset_i == soc_periph_pkg::EVT_SW) ? pwdata_i[SW_NUM-1:0] : '0;
    assign err_clr = (wr_en && offset_i == soc_periph_pkg::EVT_ERR) ? pwdata_i[EVT_NUM-1:0] : '0;
    assign evt_in  = {per_events_i & mask_q, sw_set};

    assign grant = pending_q & (~pending_q + 1'b1);   // lowest set bit
    assign push  = (|pending_q) & ~fifo_full;
    assign clr   = push ? grant : '0;
    assign lost  = evt_in & pending_q & ~clr;         // fired again before queued

    always_comb begin
        win_id = '0;
        for (int i = EVT_NUM - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                win_id = soc_periph_pkg::event_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q      <= '0;
            pending_q   <= '0;
            err_q       <= '0;
            err_event_q <= 1'b0;
        end else begin
            pending_q   <= (pending_q & ~clr) | evt_in;
            err_q       <= (err_q & ~err_clr) | lost;
            err_event_q <= |lost;
            if (wr_en && offset_i == soc_periph_pkg::EVT_MASK) begin
                mask_q <= pwdata_i[soc_periph_pkg::PER_EVT_NUM-1:0];
            end
        end
    end

    assign err_event_o = err_event_q;

    always_comb begin
        case (offset_i)
            soc_periph_pkg::EVT_MASK: prdata_o = soc_periph_pkg::apb_data_t'(mask_q);
            soc_periph_pkg::EVT_ERR:  prdata_o = soc_periph_pkg::apb_data_t'(err_q);
            default:                  prdata_o = '0; // EVT_SW reads as zero
        endcase
    end

    event_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_event_fifo (
        .clk_i   ( clk_i                               ),
        .reset_i ( reset_i                             ),
        .push_i  ( push                                ),
        .data_i  ( win_id                              ),
        .pop_i   ( fc_event_valid_o & fc_event_ready_i ),
        .full_o  ( fifo_full                           ),
        .valid_o ( fc_event_valid_o                    ),
        .data_o  ( fc_event_data_o                     )
    );

    // fabric controller sees a steady id until it takes it
    assert property (@(posedge clk_i) disable iff (reset_i)
        fc_event_valid_o && !fc_event_ready_i |=> fc_event_valid_o && $stable(fc_event_data_o))
        else $error("fc event changed under back-pressure");

endmodule

/* source/event_fifo.sv */
// event id fifo with registered storage, valid flags a non-empty queue
`timescale 1ns/10ps

module event_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      push_i,
    input  soc_periph_pkg::event_id_t data_i,
    input  logic                      pop_i,
    output logic                      full_o,
    output logic                      valid_o,
    output soc_periph_pkg::event_id_t data_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    soc_periph_pkg::event_id_t mem_q [FIFO_DEPTH];
    logic [AW:0]               wr_ptr_q;    // msb is the wrap bit
    logic [AW:0]               rd_ptr_q;

    assign valid_o = (wr_ptr_q != rd_ptr_q);
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign data_o  = mem_q[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q[AW-1:0]] <= data_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full_o)
        else $error("event fifo pushed while full");

    assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> valid_o)
        else $error("event fifo popped while empty");

endmodule

/* source/gpio_regs.sv */
// gpio block with direction, output and input registers and rising edge interrupts
`timescale 1ns/10ps

module gpio_regs #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::apb_addr_t offset_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    input  soc_periph_pkg::gpio_t     gpio_i,
    output soc_periph_pkg::gpio_t     gpio_out_o,
    output soc_periph_pkg::gpio_t     gpio_dir_o,
    output logic                      gpio_event_o
);

    soc_periph_pkg::gpio_t sync_q [SYNC_STAGES];
    soc_periph_pkg::gpio_t in_prev_q;   // edge flop
    soc_periph_pkg::gpio_t dir_q;
    soc_periph_pkg::gpio_t out_q;
    soc_periph_pkg::gpio_t inten_q;
    soc_periph_pkg::gpio_t intstat_q;
    soc_periph_pkg::gpio_t int_set;
    soc_periph_pkg::gpio_t int_clr;
    logic                  wr_en;
    logic                  event_q;

    assign wr_en   = psel_i & penable_i & pwrite_i;
    assign int_set = sync_q[SYNC_STAGES-1] & ~in_prev_q & inten_q;
    assign int_clr = (wr_en && offset_i == soc_periph_pkg::GPIO_INTSTAT) ? pwdata_i : '0;

    ////////////////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            in_prev_q <= '0;
        end else begin
            sync_q[0] <= gpio_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            in_prev_q <= sync_q[SYNC_STAGES-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // registers and interrupt status
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dir_q     <= '0;
            out_q     <= '0;
            inten_q   <= '0;
            intstat_q <= '0;
            event_q   <= 1'b0;
        end else begin
            if (wr_en) begin
                case (offset_i)
                    soc_periph_pkg::GPIO_DIR:   dir_q   <= pwdata_i;
                    soc_periph_pkg::GPIO_OUT:   out_q   <= pwdata_i;
                    soc_periph_pkg::GPIO_INTEN: inten_q <= pwdata_i;
                    default: ;
                endcase
            end
            intstat_q <= (intstat_q & ~int_clr) | int_set; // new edge beats clear
            event_q   <= |(int_set & ~intstat_q);          // only bits not yet pending
        end
    end

    always_comb begin
        case (offset_i)
            soc_periph_pkg::GPIO_DIR:     prdata_o = dir_q;
            soc_periph_pkg::GPIO_IN:      prdata_o = sync_q[SYNC_STAGES-1];
            soc_periph_pkg::GPIO_OUT:     prdata_o = out_q;
            soc_periph_pkg::GPIO_INTEN:   prdata_o = inten_q;
            soc_periph_pkg::GPIO_INTSTAT: prdata_o = intstat_q;
            default:                      prdata_o = '0;
        endcase
    end

    assign gpio_out_o   = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = event_q;

    // a second pulse needs a new edge on the synchronized pins
    assert property (@(posedge clk_i) disable iff (reset_i)
        gpio_event_o && $stable(sync_q[SYNC_STAGES-1]) |=> !gpio_event_o)
        else $error("gpio event repeated without a new input edge");

endmodule

/* source/apb_periph_decode.sv */
// apb decoder that selects the gpio or event generator region and muxes the response
`timescale 1ns/10ps

module apb_periph_decode (
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  soc_periph_pkg::apb_data_t gpio_prdata_i,
    input  soc_periph_pkg::apb_data_t evt_prdata_i,
    output logic                      gpio_psel_o,
    output logic                      evt_psel_o,
    output soc_periph_pkg::apb_addr_t offset_o,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o
);

    soc_periph_pkg::apb_addr_t region;
    logic                      gpio_hit;
    logic                      evt_hit;

    // upper bits pick the region
    assign region   = paddr_i & ~soc_periph_pkg::REGION_MASK;
    assign gpio_hit = (region == soc_periph_pkg::GPIO_BASE);
    assign evt_hit  = (region == soc_periph_pkg::EVT_BASE);

    assign gpio_psel_o = psel_i & gpio_hit;
    assign evt_psel_o  = psel_i & evt_hit;
    assign offset_o    = paddr_i & soc_periph_pkg::REGION_MASK;

    // zero wait states, every access cycle completes
    assign pready_o  = psel_i & penable_i;
    assign pslverr_o = psel_i & penable_i & ~gpio_hit & ~evt_hit; // unmapped

    always_comb begin
        prdata_o = '0;
        if (gpio_psel_o) begin
            prdata_o = gpio_prdata_i;
        end else if (evt_psel_o) begin
            prdata_o = evt_prdata_i;
        end
    end

    // one slave at most
    always_comb begin
        assert #0 (!(gpio_psel_o && evt_psel_o))
            else $error("apb decode selected more than one region");
    end

endmodule

/* source/soc_periph_pkg.sv */
// soc peripheral subsystem package with widths, address map, register offsets and event indices
package soc_periph_pkg;

    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] gpio_t;     // one bit per pin
    typedef logic [7:0]  event_id_t;
    typedef logic [7:0]  per_evt_t;
    typedef logic [31:0] fc_evt_t;

    // address map, one 4 KiB region per peripheral
    localparam apb_addr_t GPIO_BASE   = 32'h1a10_1000;
    localparam apb_addr_t EVT_BASE    = 32'h1a10_6000;
    localparam apb_addr_t REGION_MASK = 32'h0000_0fff;

    localparam apb_addr_t GPIO_DIR     = 32'h00;
    localparam apb_addr_t GPIO_IN      = 32'h04; // read only
    localparam apb_addr_t GPIO_OUT     = 32'h08;
    localparam apb_addr_t GPIO_INTEN   = 32'h0c;
    localparam apb_addr_t GPIO_INTSTAT = 32'h10; // write 1 to clear

    localparam apb_addr_t EVT_SW   = 32'h00; // sets software pending bits
    localparam apb_addr_t EVT_MASK = 32'h04;
    localparam apb_addr_t EVT_ERR  = 32'h08; // sticky overflow, w1c

    // peripheral event indices, id is 8 plus index
    localparam int PER_GPIO     = 0;
    localparam int PER_REF_RISE = 1;
    localparam int PER_REF_FALL = 2;
    localparam int PER_DMA_EVT  = 3;
    localparam int PER_DMA_IRQ  = 4;
    localparam int PER_PF_EVT   = 5;
    localparam int PER_HWPE0    = 6;
    localparam int PER_HWPE1    = 7;

    localparam int SW_EVT_NUM  = 8;
    localparam int PER_EVT_NUM = 8;

    // fast event bit positions
    localparam int FC_DMA_EVT  = 8;
    localparam int FC_DMA_IRQ  = 9;
    localparam int FC_PF_EVT   = 12;
    localparam int FC_REF_EDGE = 14;
    localparam int FC_GPIO     = 15;
    localparam int FC_ERR      = 29;

endpackage
